// ==== flist.f ====
+incdir+verilog
verilog/melody_pkg.sv
verilog/note_timer.sv
verilog/note_sequencer.sv
verilog/melody_rom.sv
verilog/pitch_shift.sv
verilog/rail_gun_player.sv
tb/player_checker.sv
tb/tb_rail_gun_player.sv

// ==== tb/player_checker.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "melody_cfg.svh"

module player_checker
    import melody_pkg::*;
#(
    parameter int BASE_PERIOD = 12
) (
    input  wire logic           iClk,
    input  wire logic           iReset_n,
    input  wire logic           enable,
    input  wire speed_sel_t     speed_sel,
    input  wire transpose_sel_t transpose_sel,
    input  wire skip_cmd_t      skip_cmd,
    input  wire pitch_t         pitch,
    input  wire progress_t      progress,
    output int                  errors,
    output int                  checks,
    output int                  notes_seen
);

    logic           en_prev;
    skip_cmd_t      skip_prev;
    speed_sel_t     speed_prev;
    progress_t      last_progress;
    int             model_idx;
    logic           armed;
    logic           hold;
    logic           back;
    int             cycles_since;
    logic           interval_ok;    // Tempo steady over the whole note
    logic           pend1;
    logic           pend2;
    int             pend1_idx;
    int             pend2_idx;
    transpose_sel_t pend2_tr;
    logic           pend2_en;

    function automatic int note_period(input int sel);
        case (sel)
            1:       return 4 * BASE_PERIOD;
            2:       return 2 * BASE_PERIOD;
            3:       return (4 * BASE_PERIOD) / 3;
            5:       return (2 * BASE_PERIOD) / 3;
            6:       return BASE_PERIOD / 2;
            7:       return BASE_PERIOD / 3;
            default: return BASE_PERIOD;
        endcase
    endfunction

    // Intro table and transpose rule
    function automatic logic [7:0] ref_pitch(input int idx, input int tsel);
        int base;
        int shift;
        case (idx % 16)
            4, 5, 6, 14: base = 41;
            8, 9, 10:    base = ((idx / 16) % 2 == 1) ? 39 : 41;
            12:          base = 39;
            default:     base = `REST_PITCH;
        endcase
        if (base == `REST_PITCH) return 8'(`REST_PITCH);
        shift = (tsel == 0) ? 0 : tsel - 4;
        return 8'(base + shift);
    endfunction

    function automatic logic is_skip(input skip_cmd_t c);
        return (c == 2'b01) || (c == 2'b10);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %0t ns %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    // Sampled on the rising edge, so outputs are the values from the edge before
    always @(posedge iClk) begin
        logic step;
        int   next_idx;
        if (!iReset_n) begin
            errors        = 0;
            checks        = 0;
            notes_seen    = 0;
            en_prev       = 1'b0;
            skip_prev     = 2'b00;
            speed_prev    = speed_sel;
            last_progress = '0;
            model_idx     = 0;
            armed         = 1'b0;
            hold          = 1'b0;
            back          = 1'b0;
            cycles_since  = 0;
            interval_ok   = 1'b0;
            pend1         = 1'b0;
            pend2         = 1'b0;
        end else begin
            cycles_since++;
            if (pend2) begin
                check_value("pitch", pend2_en ? ref_pitch(pend2_idx, pend2_tr) : `REST_PITCH,
                            pitch);
            end
            pend2     = pend1;      // Transpose is taken one cycle after the index
            pend2_idx = pend1_idx;
            pend2_tr  = transpose_sel;
            pend2_en  = enable;
            pend1     = 1'b0;
            if (!en_prev) begin
                check_value("progress", 0, progress);
                check_value("pitch", `REST_PITCH, pitch);
                model_idx     = 0;
                armed         = 1'b0;
                hold          = 1'b0;
                last_progress = progress;
                cycles_since  = 0;
                interval_ok   = 1'b0;
            end else begin
                step = (progress != last_progress);
                if (step) begin
                    next_idx = model_idx + 1;
                    if (armed) next_idx = back ? next_idx - `SKIP_STEP : next_idx + `SKIP_STEP;
                    next_idx = (next_idx + `NOTES_TOTAL) % `NOTES_TOTAL;
                    check_value("progress", next_idx * 256 / `NOTES_TOTAL, progress);
                    if (interval_ok) check_value("step interval", note_period(speed_prev),
                                                 cycles_since);
                    model_idx     = next_idx;
                    last_progress = progress;
                    cycles_since  = 0;
                    interval_ok   = 1'b1;
                    notes_seen++;
                    pend1     = 1'b1;
                    pend1_idx = next_idx;
                end
                if (armed) begin
                    if (step) begin
                        armed = 1'b0;
                        hold  = 1'b1;
                    end
                end else if (hold) begin
                    if (!is_skip(skip_prev)) hold = 1'b0;
                end else if (is_skip(skip_prev)) begin
                    armed = 1'b1;
                    back  = skip_prev[1];
                end
            end
            if (speed_sel != speed_prev) interval_ok = 1'b0;
            en_prev    = enable;
            skip_prev  = skip_cmd;
            speed_prev = speed_sel;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_rail_gun_player.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "melody_cfg.svh"

module tb_rail_gun_player
    import melody_pkg::*;
();

    localparam int BASE = 12;
    // Slow song is 66 notes at 48 cycles, the rest adds about 2500
    localparam int TIMEOUT_CYCLES = 20000;

    logic           iClk;
    logic           iReset_n;
    logic           enable;
    speed_sel_t     speed_sel;
    transpose_sel_t transpose_sel;
    skip_cmd_t      skip_cmd;
    pitch_t         pitch;
    progress_t      progress;
    int             errors;
    int             checks;
    int             notes_seen;
    int             tb_errors;
    int             cycles;
    int             rnd;

    rail_gun_player #(
        .BASE_PERIOD (BASE)
    ) rail_gun_player_i (
        .iClk          (iClk),
        .iReset_n      (iReset_n),
        .enable        (enable),
        .speed_sel     (speed_sel),
        .transpose_sel (transpose_sel),
        .skip_cmd      (skip_cmd),
        .pitch         (pitch),
        .progress      (progress)
    );

    player_checker #(
        .BASE_PERIOD (BASE)
    ) player_checker_i (
        .iClk          (iClk),
        .iReset_n      (iReset_n),
        .enable        (enable),
        .speed_sel     (speed_sel),
        .transpose_sel (transpose_sel),
        .skip_cmd      (skip_cmd),
        .pitch         (pitch),
        .progress      (progress),
        .errors        (errors),
        .checks        (checks),
        .notes_seen    (notes_seen)
    );

    initial begin
        iClk = 1'b0;
        forever #50 iClk = ~iClk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge iClk);
            cycles++;
        end
        $display("Timeout, run still going after %0d cycles", cycles);
        $display("Done: errors found");
        $finish;
    end

    // Returns on the falling edge after the count-th progress change
    task automatic wait_notes(input int count);
        progress_t last;
        int        seen;
        last = progress;
        seen = 0;
        while (seen < count) begin
            @(negedge iClk);
            if (progress != last) begin
                seen++;
                last = progress;
            end
        end
    endtask

    initial begin
        rnd           = $urandom(32'h6329e185);
        iReset_n      = 1'b0;
        enable        = 1'b0;
        speed_sel     = 3'd4;
        transpose_sel = 3'd4;
        skip_cmd      = 2'b00;
        tb_errors     = 0;
        repeat (3) @(negedge iClk);
        iReset_n = 1'b1;
        repeat (3) @(negedge iClk);

        enable = 1'b1;
        for (int sel = 0; sel < 8; sel++) begin   // Tempo sweep
            speed_sel = speed_sel_t'(sel);
            wait_notes(3);
        end

        speed_sel = 3'd1;   // Whole song at the slowest tempo
        for (int i = 0; i < 11; i++) begin
            transpose_sel = transpose_sel_t'($urandom % 8);
            wait_notes(6);
        end
        for (int i = 0; i < 4; i++) begin
            speed_sel     = speed_sel_t'($urandom % 8);
            transpose_sel = transpose_sel_t'($urandom % 8);
            wait_notes(8);
        end

        speed_sel = 3'd7;
        skip_cmd  = 2'b01;  // Held over many notes
        wait_notes(6);
        skip_cmd = 2'b00;
        wait_notes(3);
        skip_cmd = 2'b10;
        wait_notes(6);
        skip_cmd = 2'b00;
        wait_notes(3);
        skip_cmd = 2'b11;
        wait_notes(3);
        skip_cmd = 2'b00;
        wait_notes(2);

        // Turn off on a sounding note so that enable has to mute it
        while (pitch == pitch_t'(`REST_PITCH)) begin
            @(negedge iClk);
        end
        enable = 1'b0;
        repeat (5) @(negedge iClk);
        enable = 1'b1;
        wait_notes(4);
        repeat (4) @(negedge iClk);

        if (notes_seen < 2 * `NOTES_TOTAL) begin
            tb_errors++;
            $display("Too few notes played, only %0d", notes_seen);
        end
        $display("Checks: %0d, checker errors: %0d, testbench errors: %0d",
                 checks, errors, tb_errors);
        if (errors == 0 && tb_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/melody_cfg.svh ====
`ifndef MELODY_CFG_SVH
`define MELODY_CFG_SVH

// Song length in notes, the whole intro
`define NOTES_TOTAL 64

// Clock cycles per note at 1x tempo
// Must divide by 12 so that every tempo gives a whole period
`define BASE_PERIOD_CYCLES 105840

// Pitch code for silence
`define REST_PITCH 100

// Notes jumped by one skip command
`define SKIP_STEP 5

// Entries held by the melody table
`define MELODY_TABLE_SIZE 64

`endif

// ==== verilog/melody_pkg.sv ====
`default_nettype none

package melody_pkg;

    // Song position
    typedef logic [9:0] note_index_t;

    // Semitone pitch code, the rest code included
    typedef logic [7:0] pitch_t;

    // Note period in clock cycles
    typedef logic [20:0] period_t;

    typedef logic [2:0] speed_sel_t;      // 0 and 4 are 1x
    typedef logic [2:0] transpose_sel_t;  // 4 is no shift

    // 01 forward, 10 back, 00 and 11 idle
    typedef logic [1:0] skip_cmd_t;

    // Fraction of the song, 256 is the full song
    typedef logic [7:0] progress_t;

    typedef enum logic [1:0] {
        SKIP_IDLE,
        SKIP_ARMED,
        SKIP_HOLD
    } skip_state_t;

endpackage

`default_nettype wire

// ==== verilog/melody_rom.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "melody_cfg.svh"

module melody_rom
    import melody_pkg::*;
(
    input  wire logic        iClk,
    input  wire logic        iReset_n,
    input  wire note_index_t note_index,
    output pitch_t           base_pitch
);

    localparam pitch_t REST    = pitch_t'(`REST_PITCH);
    localparam pitch_t NOTE_HI = 8'd41;
    localparam pitch_t NOTE_LO = 8'd39;

    logic [3:0] pos;        // Note within the 16-note phrase
    logic       phrase_b;   // Second and fourth phrase

    assign pos      = note_index[3:0];
    assign phrase_b = note_index[4];

    // Intro is phrase A, B, A, B
    always_ff @(posedge iClk or negedge iReset_n) begin
        if (!iReset_n) begin
            base_pitch <= REST;
        end else if (note_index >= note_index_t'(`MELODY_TABLE_SIZE)) begin
            base_pitch <= REST;
        end else begin
            case (pos)
                4'd0:  base_pitch <= REST;
                4'd1:  base_pitch <= REST;
                4'd2:  base_pitch <= REST;
                4'd3:  base_pitch <= REST;
                4'd4:  base_pitch <= NOTE_HI;
                4'd5:  base_pitch <= NOTE_HI;
                4'd6:  base_pitch <= NOTE_HI;
                4'd7:  base_pitch <= REST;
                // Only these three differ between the phrases
                4'd8:  base_pitch <= phrase_b ? NOTE_LO : NOTE_HI;
                4'd9:  base_pitch <= phrase_b ? NOTE_LO : NOTE_HI;
                4'd10: base_pitch <= phrase_b ? NOTE_LO : NOTE_HI;
                4'd11: base_pitch <= REST;
                4'd12: base_pitch <= NOTE_LO;
                4'd13: base_pitch <= REST;
                4'd14: base_pitch <= NOTE_HI;
                4'd15: base_pitch <= REST;
                default: base_pitch <= REST;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/note_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "melody_cfg.svh"

module note_sequencer
    import melody_pkg::*;
(
    input  wire logic      iClk,
    input  wire logic      iReset_n,
    input  wire logic      enable,
    input  wire logic      step,
    input  wire skip_cmd_t skip_cmd,
    output note_index_t    note_index,
    output progress_t      progress
);

    skip_state_t skip_state;
    logic        skip_back;     // Direction of the armed skip
    logic        cmd_valid;
    note_index_t raw_index;
    note_index_t next_index;
    logic [17:0] progress_full;

    assign cmd_valid = (skip_cmd == 2'b01) || (skip_cmd == 2'b10);

    // Sum stays below twice the song length, one subtract wraps it
    always_comb begin
        raw_index = note_index + note_index_t'(1);
        if (skip_state == SKIP_ARMED) begin
            if (skip_back) begin
                raw_index = raw_index + note_index_t'(`NOTES_TOTAL - `SKIP_STEP);
            end else begin
                raw_index = raw_index + note_index_t'(`SKIP_STEP);
            end
        end
        if (raw_index >= note_index_t'(`NOTES_TOTAL)) begin
            next_index = raw_index - note_index_t'(`NOTES_TOTAL);
        end else begin
            next_index = raw_index;
        end
    end

    // index * 256 / song length
    assign progress_full = {next_index, 8'd0} / 18'(`NOTES_TOTAL);

    always_ff @(posedge iClk or negedge iReset_n) begin
        if (!iReset_n) begin
            note_index <= '0;
            progress   <= '0;
            skip_state <= SKIP_IDLE;
            skip_back  <= 1'b0;
        end else if (!enable) begin
            note_index <= '0;
            progress   <= '0;
            skip_state <= SKIP_IDLE;
            skip_back  <= 1'b0;
        end else begin
            if (step) begin
                note_index <= next_index;
                progress   <= progress_t'(progress_full);
            end

            case (skip_state)
                SKIP_IDLE: begin
                    if (cmd_valid) begin
                        skip_state <= SKIP_ARMED;
                        skip_back  <= skip_cmd[1];
                    end
                end
                SKIP_ARMED: begin
                    if (step) skip_state <= SKIP_HOLD;  // Offset used up
                end
                SKIP_HOLD: begin
                    // Wait for release so a held command counts once
                    if (!cmd_valid) skip_state <= SKIP_IDLE;
                end
                default: skip_state <= SKIP_IDLE;
            endcase
        end
    end

    a_index_range: assert property (@(posedge iClk) disable iff (!iReset_n)
        note_index < note_index_t'(`NOTES_TOTAL))
        else $error("note_index %0d out of song range", note_index);

endmodule

`default_nettype wire

// ==== verilog/note_timer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "melody_cfg.svh"

module note_timer
    import melody_pkg::*;
#(
    parameter int BASE_PERIOD = `BASE_PERIOD_CYCLES
) (
    input  wire logic       iClk,
    input  wire logic       iReset_n,
    input  wire logic       enable,
    input  wire speed_sel_t speed_sel,
    output logic            step
);

    localparam period_t PERIOD_4B  = period_t'(4 * BASE_PERIOD);
    localparam period_t PERIOD_2B  = period_t'(2 * BASE_PERIOD);
    localparam period_t PERIOD_4B3 = period_t'((4 * BASE_PERIOD) / 3);
    localparam period_t PERIOD_B   = period_t'(BASE_PERIOD);
    localparam period_t PERIOD_2B3 = period_t'((2 * BASE_PERIOD) / 3);
    localparam period_t PERIOD_B2  = period_t'(BASE_PERIOD / 2);
    localparam period_t PERIOD_B3  = period_t'(BASE_PERIOD / 3);

    period_t period_sel;
    period_t period_r;
    period_t count;

    // Slowest tempo first
    always_comb begin
        case (speed_sel)
            3'd1:    period_sel = PERIOD_4B;
            3'd2:    period_sel = PERIOD_2B;
            3'd3:    period_sel = PERIOD_4B3;
            3'd4:    period_sel = PERIOD_B;
            3'd5:    period_sel = PERIOD_2B3;
            3'd6:    period_sel = PERIOD_B2;
            3'd7:    period_sel = PERIOD_B3;
            default: period_sel = PERIOD_B;
        endcase
    end

    // A late tempo change can leave count above the new end, >= catches it
    assign step = enable && (count >= period_r - period_t'(1));

    always_ff @(posedge iClk or negedge iReset_n) begin
        if (!iReset_n) begin
            period_r <= PERIOD_B;
            count    <= '0;
        end else begin
            period_r <= period_sel;
            if (!enable || step) begin
                count <= '0;
            end else begin
                count <= count + period_t'(1);
            end
        end
    end

    a_step_single: assert property (@(posedge iClk) disable iff (!iReset_n)
        step |=> !step)
        else $error("step held high for two cycles");

endmodule

`default_nettype wire

// ==== verilog/pitch_shift.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "melody_cfg.svh"

module pitch_shift
    import melody_pkg::*;
(
    input  wire logic           iClk,
    input  wire logic           iReset_n,
    input  wire logic           enable,
    input  wire transpose_sel_t transpose_sel,
    input  wire pitch_t         base_pitch,
    output pitch_t              pitch
);

    localparam pitch_t REST = pitch_t'(`REST_PITCH);

    logic [2:0] shift;      // Two's complement, -3 to +3
    pitch_t     offset;
    pitch_t     shifted;

    // sel - 4 wraps to the right code for 1..7
    assign shift   = (transpose_sel == 3'd0) ? 3'd0 : 3'(transpose_sel - 3'd4);
    assign offset  = {{5{shift[2]}}, shift};
    assign shifted = base_pitch + offset;

    always_ff @(posedge iClk or negedge iReset_n) begin
        if (!iReset_n) begin
            pitch <= REST;
        end else if (!enable || base_pitch == REST) begin
            pitch <= REST;  // Silence is never moved
        end else begin
            pitch <= shifted;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rail_gun_player.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "melody_cfg.svh"

module rail_gun_player
    import melody_pkg::*;
#(
    parameter int BASE_PERIOD = `BASE_PERIOD_CYCLES
) (
    input  wire logic           iClk,
    input  wire logic           iReset_n,
    input  wire logic           enable,
    input  wire speed_sel_t     speed_sel,
    input  wire transpose_sel_t transpose_sel,
    input  wire skip_cmd_t      skip_cmd,
    output pitch_t              pitch,
    output progress_t           progress
);

    logic        step;
    note_index_t note_index;
    pitch_t      base_pitch;

    note_timer #(
        .BASE_PERIOD (BASE_PERIOD)
    ) note_timer_i (
        .iClk      (iClk),
        .iReset_n  (iReset_n),
        .enable    (enable),
        .speed_sel (speed_sel),
        .step      (step)
    );

    note_sequencer note_sequencer_i (
        .iClk       (iClk),
        .iReset_n   (iReset_n),
        .enable     (enable),
        .step       (step),
        .skip_cmd   (skip_cmd),
        .note_index (note_index),
        .progress   (progress)
    );

    // Two register stages from index to pitch
    melody_rom melody_rom_i (
        .iClk       (iClk),
        .iReset_n   (iReset_n),
        .note_index (note_index),
        .base_pitch (base_pitch)
    );

    pitch_shift pitch_shift_i (
        .iClk          (iClk),
        .iReset_n      (iReset_n),
        .enable        (enable),
        .transpose_sel (transpose_sel),
        .base_pitch    (base_pitch),
        .pitch         (pitch)
    );

endmodule

`default_nettype wire
